//--- sim.f
common/eth_pkg.sv
common/arp_pkg.sv
common/byte_stream_if.sv
hw/crc32_d8.sv
hw/arp_source/arp_request_source.sv
hw/eth_tx/eth_header_inserter.sv
hw/eth_tx/gmii_fcs_tx.sv
hw/arp_tx_top.sv
verif/tb_arp_tx.sv

//--- run_sim.sh
#!/bin/sh
# build the ARP transmit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_arp_tx -o tb_arp_tx
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/tb_arp_tx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

//--- verif/tb_arp_tx.sv
`timescale 1ns/1ps

module tb_arp_tx;

	import eth_pkg::*;
	import arp_pkg::*;

	localparam int REQ_INTERVAL = 200;
	localparam int FRAME_LEN    = 72;
	localparam int NUM_ROWS     = 6;
	localparam int TIMEOUT      = 6 * (REQ_INTERVAL + FRAME_LEN + IFG_LEN) * 2;

	logic       gmii_tx_clk;
	logic       rst_n;
	logic       enable;
	mac_addr_t  src_mac;
	ip_addr_t   src_ip;
	ip_addr_t   target_ip;
	logic       gmii_tx_en;
	logic       gmii_tx_er;
	logic [7:0] gmii_tx_data;
	logic       phy_rst_n;

	// test table, row_len 0 means no frame may appear
	string     row_name [NUM_ROWS];
	logic      row_en   [NUM_ROWS];
	mac_addr_t row_mac  [NUM_ROWS];
	ip_addr_t  row_ip   [NUM_ROWS];
	ip_addr_t  row_tip  [NUM_ROWS];
	int        row_len  [NUM_ROWS];

	logic [7:0]  exp_frame [FRAME_LEN];
	logic [7:0]  got [$];
	logic [15:0] lfsr;
	int          errs;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          cycles = 0;
	int          low_cycles;
	int          er_cycles;

	arp_tx_top #(
		.REQ_INTERVAL (REQ_INTERVAL)
	) uut (
		.gmii_tx_clk  (gmii_tx_clk),
		.rst_n        (rst_n),
		.enable       (enable),
		.src_mac      (src_mac),
		.src_ip       (src_ip),
		.target_ip    (target_ip),
		.gmii_tx_en   (gmii_tx_en),
		.gmii_tx_er   (gmii_tx_er),
		.gmii_tx_data (gmii_tx_data),
		.phy_rst_n    (phy_rst_n)
	);

	initial
	begin
		gmii_tx_clk = 1'b0;
		forever #5 gmii_tx_clk = ~gmii_tx_clk;
	end

	always @(posedge gmii_tx_clk)
	begin
		cycles++;
		if (cycles > TIMEOUT)
		begin
			$display("run stopped, no result after %0d cycles", TIMEOUT);
			$display("TB FAILED");
			$finish;
		end
	end

	// 16 bit Galois LFSR, taps 16 14 13 11
	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
		return b;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++)
			b[i] = take_bit();
		return b;
	endfunction

	function automatic void put_field(input int pos, input logic [47:0] v, input int nbytes);
		for (int k = 0; k < nbytes; k++)
			exp_frame[pos + k] = v[8 * (nbytes - 1 - k) +: 8];
	endfunction

	// MSB-first CRC-32 over the expected frame, reversed at the end for wire order
	function automatic logic [31:0] ref_fcs(input int first, input int count);
		logic [31:0] r;
		logic [31:0] refl;
		logic        fb;
		r = 32'hFFFF_FFFF;
		for (int n = first; n < first + count; n++)
			for (int i = 0; i < 8; i++)
			begin
				fb = r[31] ^ exp_frame[n][i];
				r = {r[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
			end
		for (int i = 0; i < 32; i++)
			refl[i] = r[31 - i];
		return ~refl;
	endfunction

	function automatic void build_frame(input mac_addr_t mac, input ip_addr_t ip,
		input ip_addr_t tip);
		logic [31:0] fcs;
		for (int n = 0; n < FRAME_LEN; n++)
			exp_frame[n] = (n < PREAMBLE_LEN) ? PREAMBLE_BYTE : 8'h00;
		exp_frame[PREAMBLE_LEN] = SFD_BYTE;
		put_field(8, BCAST_MAC, 6);
		put_field(14, mac, 6);
		put_field(20, ETHERTYPE_ARP, 2);
		// ARP body from byte 22, padding stays zero
		put_field(22, ARP_HTYPE_ETH, 2);
		put_field(24, ARP_PTYPE_IPV4, 2);
		put_field(26, ARP_HLEN, 1);
		put_field(27, ARP_PLEN, 1);
		put_field(28, ARP_OP_REQUEST, 2);
		put_field(30, mac, 6);
		put_field(36, ip, 4);
		put_field(46, tip, 4);
		fcs = ref_fcs(8, FRAME_LEN - 8 - FCS_LEN);
		for (int k = 0; k < FCS_LEN; k++)
			exp_frame[68 + k] = fcs[8 * k +: 8];
	endfunction

	function automatic mac_addr_t mac_at(input int pos);
		mac_addr_t m;
		m = '0;
		for (int k = 0; k < 6; k++)
			m = {m[39:0], got[pos + k]};
		return m;
	endfunction

	function automatic ip_addr_t ip_at(input int pos);
		ip_addr_t a;
		a = '0;
		for (int k = 0; k < 4; k++)
			a = {a[23:0], got[pos + k]};
		return a;
	endfunction

	// bytes covered by the MAC and IP compares
	function automatic logic in_field(input int n);
		return (n >= 8 && n < 20) || (n >= 30 && n < 40) || (n >= 46 && n < 50);
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %02h, got %02h", name, exp, act);
			errs++;
		end
	endtask

	task automatic check_mac(input string name, input mac_addr_t exp, input mac_addr_t act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %012h, got %012h", name, exp, act);
			errs++;
		end
	endtask

	task automatic check_ip(input string name, input ip_addr_t exp, input ip_addr_t act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %08h, got %08h", name, exp, act);
			errs++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act,
		input logic at_least);
		if (at_least ? (act < exp) : (act != exp))
		begin
			$display("FAILED %s: expected %s%0d, got %0d", name, at_least ? "at least " : "",
				exp, act);
			errs++;
		end
	endtask

	task automatic check_idle(input string when);
		if (gmii_tx_en !== 1'b0 || gmii_tx_er !== 1'b0)
		begin
			$display("%s: gmii_tx_en or gmii_tx_er is not low", when);
			errs++;
		end
		if (phy_rst_n !== 1'b1)
		begin
			$display("%s: phy_rst_n is not high", when);
			errs++;
		end
	endtask

	// one frame, counting the low cycles since the previous one
	task capture_frame();
		// the negedge where the previous frame dropped tx_en counts as low
		low_cycles = 1;
		er_cycles = 0;
		got.delete();
		@(negedge gmii_tx_clk);
		while (gmii_tx_en !== 1'b1)
		begin
			low_cycles++;
			@(negedge gmii_tx_clk);
		end
		while (gmii_tx_en === 1'b1)
		begin
			got.push_back(gmii_tx_data);
			if (gmii_tx_er !== 1'b0)
				er_cycles++;
			@(negedge gmii_tx_clk);
		end
	endtask

	task automatic check_frame(input int r);
		build_frame(row_mac[r], row_ip[r], row_tip[r]);
		check_count({row_name[r], " tx_en length"}, row_len[r], got.size(), 1'b0);
		check_count({row_name[r], " tx_er cycles"}, 0, er_cycles, 1'b0);
		// the interval starts at the end of the payload, the FCS uses part of it
		if (r > 0)
			check_count({row_name[r], " gap"}, REQ_INTERVAL - FCS_LEN, low_cycles, 1'b1);
		if (got.size() == FRAME_LEN)
		begin
			check_mac({row_name[r], " dest mac"}, BCAST_MAC, mac_at(8));
			check_mac({row_name[r], " src mac"}, row_mac[r], mac_at(14));
			check_mac({row_name[r], " sender mac"}, row_mac[r], mac_at(30));
			check_ip({row_name[r], " sender ip"}, row_ip[r], ip_at(36));
			check_ip({row_name[r], " target ip"}, row_tip[r], ip_at(46));
			for (int n = 0; n < FRAME_LEN; n++)
				if (!in_field(n))
					check_byte($sformatf("%s byte %0d", row_name[r], n), exp_frame[n], got[n]);
		end
	endtask

	task automatic check_quiet(input int r);
		int rises;
		rises = 0;
		repeat (3 * REQ_INTERVAL)
		begin
			@(negedge gmii_tx_clk);
			if (gmii_tx_en !== 1'b0)
				rises++;
		end
		if (rises != 0)
		begin
			$display("%s: gmii_tx_en went high although enable is low", row_name[r]);
			errs++;
		end
	endtask

	task automatic report(input string name);
		if (errs == 0)
		begin
			pass_cnt++;
			$display("test %s ok", name);
		end
		else
		begin
			fail_cnt++;
			$display("test %s failed with %0d mismatches", name, errs);
		end
	endtask

	initial
	begin
		rst_n     = 1'b0;
		enable    = 1'b0;
		src_mac   = '0;
		src_ip    = '0;
		target_ip = '0;
		lfsr      = 16'd59784;

		row_name[0] = "ref_addr";
		row_en[0]   = 1'b1;
		row_mac[0]  = 48'h000a_3501_fec0;
		row_ip[0]   = 32'hc0a8_0002;
		row_tip[0]  = 32'hc0a8_0003;
		row_name[1] = "private_net";
		row_en[1]   = 1'b1;
		row_mac[1]  = 48'h0200_0000_0001;
		row_ip[1]   = 32'h0a00_0001;
		row_tip[1]  = 32'h0a00_00fe;
		row_name[2] = "high_bits";
		row_en[2]   = 1'b1;
		row_mac[2]  = 48'hfeff_ffff_ffff;
		row_ip[2]   = 32'hffff_fffe;
		row_tip[2]  = 32'hffff_ffff;
		row_name[3] = "all_zero";
		row_en[3]   = 1'b1;
		row_mac[3]  = '0;
		row_ip[3]   = '0;
		row_tip[3]  = '0;
		row_name[4] = "lfsr_addr";
		row_en[4]   = 1'b1;
		row_mac[4]  = '0;
		row_ip[4]   = '0;
		row_tip[4]  = '0;
		for (int k = 0; k < 6; k++)
			row_mac[4] = {row_mac[4][39:0], rand_byte()};
		for (int k = 0; k < 4; k++)
			row_ip[4] = {row_ip[4][23:0], rand_byte()};
		for (int k = 0; k < 4; k++)
			row_tip[4] = {row_tip[4][23:0], rand_byte()};
		row_name[5] = "disabled";
		row_en[5]   = 1'b0;
		row_mac[5]  = row_mac[0];
		row_ip[5]   = row_ip[0];
		row_tip[5]  = row_tip[0];
		for (int r = 0; r < NUM_ROWS; r++)
			row_len[r] = row_en[r] ? FRAME_LEN : 0;

		errs = 0;
		repeat (4)
		begin
			@(negedge gmii_tx_clk);
			check_idle("during reset");
		end
		@(posedge gmii_tx_clk);
		#1;
		rst_n = 1'b1;
		@(negedge gmii_tx_clk);
		check_idle("after reset");
		report("reset");

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			errs = 0;
			@(posedge gmii_tx_clk);
			#1;
			enable    = row_en[r];
			src_mac   = row_mac[r];
			src_ip    = row_ip[r];
			target_ip = row_tip[r];
			if (row_len[r] == 0)
				check_quiet(r);
			else
			begin
				capture_frame();
				check_frame(r);
			end
			report(row_name[r]);
		end

		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- hw/arp_tx_top.sv
`timescale 1ns/1ps

module arp_tx_top #(
	parameter int REQ_INTERVAL = 2**24
) (
	input  logic               gmii_tx_clk,
	input  logic               rst_n,
	input  logic               enable,
	input  eth_pkg::mac_addr_t src_mac,
	input  arp_pkg::ip_addr_t  src_ip,
	input  arp_pkg::ip_addr_t  target_ip,
	output logic               gmii_tx_en,
	output logic               gmii_tx_er,
	output logic [7:0]         gmii_tx_data,
	output logic               phy_rst_n
);

	byte_stream_if payload_s ();
	byte_stream_if frame_s ();

	// no PHY management here, keep it out of reset
	assign phy_rst_n = 1'b1;

	arp_request_source #(
		.REQ_INTERVAL (REQ_INTERVAL)
	) u_source (
		.gmii_tx_clk (gmii_tx_clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.src_mac     (src_mac),
		.src_ip      (src_ip),
		.target_ip   (target_ip),
		.payload     (payload_s.source)
	);

	eth_header_inserter u_header (
		.gmii_tx_clk (gmii_tx_clk),
		.rst_n       (rst_n),
		.src_mac     (src_mac),
		.payload     (payload_s.sink),
		.frame       (frame_s.source)
	);

	gmii_fcs_tx u_gmii (
		.gmii_tx_clk  (gmii_tx_clk),
		.rst_n        (rst_n),
		.frame        (frame_s.sink),
		.gmii_tx_en   (gmii_tx_en),
		.gmii_tx_er   (gmii_tx_er),
		.gmii_tx_data (gmii_tx_data)
	);

endmodule

//--- hw/eth_tx/gmii_fcs_tx.sv
`timescale 1ns/1ps

module gmii_fcs_tx (
	input  logic        gmii_tx_clk,
	input  logic        rst_n,
	byte_stream_if.sink frame,
	output logic        gmii_tx_en,
	output logic        gmii_tx_er,
	output logic [7:0]  gmii_tx_data
);

	import eth_pkg::*;

	// CRC starts with the first byte after the SFD
	localparam int CRC_START = PREAMBLE_LEN + 1;
	localparam int BC_W      = $clog2(CRC_START + 1);
	localparam int PC_W      = $clog2(IFG_LEN);

	typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_FCS, ST_GAP} state_t;

	state_t          state;
	logic [BC_W-1:0] byte_cnt;
	logic [PC_W-1:0] phase_cnt;
	logic            xfer;
	logic            crc_init;
	logic            crc_en;
	logic [31:0]     fcs;
	logic [7:0]      fcs_byte;

	assign frame.ready = (state == ST_IDLE) || (state == ST_DATA);
	assign xfer        = frame.valid && frame.ready;
	assign crc_init    = (state == ST_IDLE);
	assign crc_en      = xfer && (byte_cnt == BC_W'(CRC_START));

	// fcs[7:0] goes out first
	assign fcs_byte = 8'(fcs >> (phase_cnt * 8));

	assign gmii_tx_er = 1'b0;

	crc32_d8 u_crc (
		.gmii_tx_clk (gmii_tx_clk),
		.rst_n       (rst_n),
		.init        (crc_init),
		.enable      (crc_en),
		.data        (frame.data),
		.fcs         (fcs)
	);

	always_ff @(posedge gmii_tx_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= ST_IDLE;
			byte_cnt   <= '0;
			phase_cnt  <= '0;
			gmii_tx_en <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					gmii_tx_en <= xfer;
					if (xfer)
					begin
						state    <= ST_DATA;
						byte_cnt <= BC_W'(1);
					end
				end
				ST_DATA:
				begin
					gmii_tx_en <= xfer;
					// saturates once the CRC window is open
					if (xfer && byte_cnt != BC_W'(CRC_START))
						byte_cnt <= byte_cnt + 1'b1;
					if (xfer && frame.last)
					begin
						state     <= ST_FCS;
						phase_cnt <= '0;
					end
				end
				ST_FCS:
				begin
					gmii_tx_en <= 1'b1;
					phase_cnt  <= phase_cnt + 1'b1;
					if (phase_cnt == PC_W'(FCS_LEN - 1))
					begin
						state     <= ST_GAP;
						phase_cnt <= '0;
					end
				end
				ST_GAP:
				begin
					gmii_tx_en <= 1'b0;
					phase_cnt  <= phase_cnt + 1'b1;
					if (phase_cnt == PC_W'(IFG_LEN - 1))
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge gmii_tx_clk)
	begin
		if (state == ST_FCS)
			gmii_tx_data <= fcs_byte;
		else
			gmii_tx_data <= frame.data;
	end

	// tx_en drops only after the FCS, never in the middle of a frame
	a_en_fall: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
		$fell(gmii_tx_en) |-> state == ST_GAP);

endmodule

//--- hw/eth_tx/eth_header_inserter.sv
`timescale 1ns/1ps

module eth_header_inserter (
	input  logic               gmii_tx_clk,
	input  logic               rst_n,
	input  eth_pkg::mac_addr_t src_mac,
	byte_stream_if.sink        payload,
	byte_stream_if.source      frame
);

	import eth_pkg::*;

	// preamble, SFD, two MAC addresses, EtherType
	localparam int HDR_LEN = PREAMBLE_LEN + 1 + 2 * ($bits(mac_addr_t) / 8) + 2;
	localparam int HDR_W   = HDR_LEN * 8;
	localparam int CNT_W   = $clog2(HDR_LEN);

	typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PASS} state_t;

	state_t           state;
	logic [CNT_W-1:0] hdr_cnt;
	mac_addr_t        mac_q;
	logic [HDR_W-1:0] hdr_vec;
	logic [HDR_W-1:0] hdr_sh;

	always_ff @(posedge gmii_tx_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= ST_IDLE;
			hdr_cnt <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (payload.valid)
					begin
						state   <= ST_HDR;
						hdr_cnt <= '0;
					end
				end
				ST_HDR:
				begin
					// valid is always high here, so ready means a transfer
					if (frame.ready)
					begin
						if (hdr_cnt == CNT_W'(HDR_LEN - 1))
							state <= ST_PASS;
						else
							hdr_cnt <= hdr_cnt + 1'b1;
					end
				end
				ST_PASS:
				begin
					if (payload.valid && frame.ready && payload.last)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge gmii_tx_clk)
	begin
		if (state == ST_IDLE && payload.valid)
			mac_q <= src_mac;
	end

	assign hdr_vec = {{PREAMBLE_LEN{PREAMBLE_BYTE}}, SFD_BYTE, BCAST_MAC, mac_q, ETHERTYPE_ARP};
	assign hdr_sh  = hdr_vec << (hdr_cnt * 8);

	always_comb
	begin
		frame.valid   = 1'b0;
		frame.data    = hdr_sh[HDR_W-1 -: 8];
		frame.last    = 1'b0;
		payload.ready = 1'b0;
		case (state)
			ST_HDR:
				frame.valid = 1'b1;
			ST_PASS:
			begin
				frame.valid   = payload.valid;
				frame.data    = payload.data;
				frame.last    = payload.last;
				payload.ready = frame.ready;
			end
			default: ;
		endcase
	end

	// the payload byte waiting behind the header stays offered and is never a frame end
	a_no_last_in_hdr: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
		state == ST_HDR |-> payload.valid && !payload.last);

endmodule

//--- hw/arp_source/arp_request_source.sv
`timescale 1ns/1ps

module arp_request_source #(
	parameter int REQ_INTERVAL = 2**24
) (
	input  logic               gmii_tx_clk,
	input  logic               rst_n,
	input  logic               enable,
	input  eth_pkg::mac_addr_t src_mac,
	input  arp_pkg::ip_addr_t  src_ip,
	input  arp_pkg::ip_addr_t  target_ip,
	byte_stream_if.source      payload
);

	import eth_pkg::*;
	import arp_pkg::*;

	localparam int CNT_W  = $clog2(REQ_INTERVAL + 1);
	localparam int IDX_W  = $clog2(MIN_PAYLOAD_LEN);
	localparam int BODY_W = ARP_BODY_LEN * 8;

	logic [CNT_W-1:0]  gap_cnt;
	logic [IDX_W-1:0]  idx;
	logic              active;
	logic              launch;
	logic              xfer;
	mac_addr_t         mac_q;
	ip_addr_t          ip_q;
	ip_addr_t          tip_q;
	logic [BODY_W-1:0] body;
	logic [BODY_W-1:0] body_sh;

	assign launch = !active && enable && (gap_cnt == CNT_W'(REQ_INTERVAL));
	assign xfer   = payload.valid && payload.ready;

	always_ff @(posedge gmii_tx_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active  <= 1'b0;
			idx     <= '0;
			gap_cnt <= '0;
		end
		else if (active)
		begin
			// step only on a taken byte, hold under back-pressure
			if (xfer)
			begin
				if (payload.last)
					active <= 1'b0;
				idx <= idx + 1'b1;
			end
		end
		else if (launch)
		begin
			active  <= 1'b1;
			idx     <= '0;
			gap_cnt <= '0;
		end
		else if (enable)
			gap_cnt <= gap_cnt + 1'b1;
		else
			gap_cnt <= '0;
	end

	// config snapshot so a frame never mixes old and new addresses
	always_ff @(posedge gmii_tx_clk)
	begin
		if (launch)
		begin
			mac_q <= src_mac;
			ip_q  <= src_ip;
			tip_q <= target_ip;
		end
	end

	assign body = {ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN, ARP_OP_REQUEST,
		mac_q, ip_q, 48'h0, tip_q};

	// past the ARP body the shift runs out and yields the zero padding
	assign body_sh = body << (idx * 8);

	assign payload.data  = body_sh[BODY_W-1 -: 8];
	assign payload.valid = active;
	assign payload.last  = (idx == IDX_W'(MIN_PAYLOAD_LEN - 1));

	// a byte on offer must not change until it is taken
	a_hold_stable: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
		payload.valid && !payload.ready |=>
			payload.valid && $stable(payload.data) && $stable(payload.last));

endmodule

//--- hw/crc32_d8.sv
`timescale 1ns/1ps

module crc32_d8 (
	input  logic        gmii_tx_clk,
	input  logic        rst_n,
	input  logic        init,
	input  logic        enable,
	input  logic [7:0]  data,
	output logic [31:0] fcs
);

	// 0x04C11DB7 bit reversed, data enters LSB first
	localparam logic [31:0] POLY_REFL = 32'hEDB88320;

	logic [31:0] crc_q;

	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++)
			r = (r >> 1) ^ ((r[0] ^ d[i]) ? POLY_REFL : 32'h0);
		return r;
	endfunction

	always_ff @(posedge gmii_tx_clk or negedge rst_n)
	begin
		if (!rst_n)
			crc_q <= '1;
		else if (init)
			crc_q <= '1;
		else if (enable)
			crc_q <= crc_step(crc_q, data);
	end

	// reflected register already has the wire order, low byte first
	assign fcs = ~crc_q;

endmodule

//--- common/byte_stream_if.sv
`timescale 1ns/1ps

interface byte_stream_if;

	logic [7:0] data;
	logic       valid;
	logic       ready;
	logic       last;

	modport source (
		output data,
		output valid,
		output last,
		input  ready
	);

	modport sink (
		input  data,
		input  valid,
		input  last,
		output ready
	);

endinterface

//--- common/arp_pkg.sv
package arp_pkg;

	typedef logic [31:0] ip_addr_t;

	// fixed fields of an ARP request over Ethernet/IPv4
	localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
	localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  ARP_HLEN       = 8'd6;
	localparam logic [7:0]  ARP_PLEN       = 8'd4;
	localparam logic [15:0] ARP_OP_REQUEST = 16'h0001;

	// htype, ptype, hlen, plen, oper, two MAC/IP pairs
	localparam int ARP_BODY_LEN = 28;

endpackage

//--- common/eth_pkg.sv
package eth_pkg;

	typedef logic [47:0] mac_addr_t;

	// GMII framing bytes ahead of the MAC header
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE      = 8'hD5;
	localparam int         PREAMBLE_LEN  = 7;

	localparam mac_addr_t   BCAST_MAC     = 48'hFFFF_FFFF_FFFF;
	localparam logic [15:0] ETHERTYPE_ARP = 16'h0806;

	// shortest payload that still gives a 64 byte frame with FCS
	localparam int MIN_PAYLOAD_LEN = 46;

	localparam int FCS_LEN = 4;

	// interframe gap in byte times
	localparam int IFG_LEN = 12;

endpackage
